// File: Bender.yml
package:
  name: sdram_self_test

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sdram_test_pkg.sv
      - rtl/uart_byte_tx.sv
      - rtl/burst_pattern_gen.sv
      - rtl/burst_verifier.sv
      - rtl/sdram_self_test.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/tb_sdram_self_test.sv

// File: rtl/burst_pattern_gen.sv
`timescale 1ns/1ns

`include "sdram_test_settings.svh"

module burst_pattern_gen
    import sdram_test_pkg::*;
#(
    parameter int pace_cycles = `PACE_CYCLES_DEFAULT, // Pause after a good burst.
    parameter int frame_words = `FRAME_WORDS_DEFAULT  // Multiple of the burst length.
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,
    input  logic        burst_ok,    // Whole burst sent on the UART.
    output logic        burst_start, // One-cycle launch to the verifier.
    output sdram_addr_t mem_addr,
    output sdram_word_u wr_word      // Same value in all four words.
);

    localparam int PACE_W = $clog2(pace_cycles + 1);

    // Address of the final burst in the frame.
    localparam sdram_addr_t LAST_ADDR = sdram_addr_t'(frame_words - `BURST_WORDS);

    // FSM encoding.
    localparam logic [1:0] ST_LAUNCH = 2'd0;
    localparam logic [1:0] ST_RUN    = 2'd1;
    localparam logic [1:0] ST_PACE   = 2'd2;
    localparam logic [1:0] ST_HALT   = 2'd3;

    logic [1:0]        state;
    logic [PACE_W-1:0] pace_cnt;

    //////////////////////////////////////////////////
    // Burst sequencing and pacing.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_LAUNCH; // First burst right after reset.
            pace_cnt    <= '0;
            burst_start <= 1'b0;
            mem_addr    <= '0;
            wr_word     <= '0;
        end else begin
            burst_start <= 1'b0; // Pulse by default low.
            case (state)
                ST_LAUNCH: begin
                    burst_start <= 1'b1;
                    state       <= ST_RUN;
                end

                ST_RUN: begin // Verifier owns the burst.
                    if (burst_ok) begin
                        pace_cnt <= '0;
                        state    <= ST_PACE;
                    end
                end

                ST_PACE: begin
                    if (pace_cnt == PACE_W'(pace_cycles - 1)) begin
                        pace_cnt <= '0;
                        if (mem_addr == LAST_ADDR) begin
                            state <= ST_HALT; // Frame done, no error.
                        end else begin
                            mem_addr     <= mem_addr + sdram_addr_t'(`BURST_WORDS);
                            wr_word.word <= wr_word.word + 1'b1; // Next pattern.
                            state        <= ST_LAUNCH;
                        end
                    end else begin
                        pace_cnt <= pace_cnt + 1'b1;
                    end
                end

                ST_HALT: begin
                    state <= ST_HALT; // Only reset leaves.
                end

                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

endmodule

// File: rtl/burst_verifier.sv
`timescale 1ns/1ns

`include "sdram_test_settings.svh"

module burst_verifier
    import sdram_test_pkg::*;
#(
    parameter int baud_div = `UART_BAUD_DIV_DEFAULT
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,
    input  logic        burst_start,
    input  sdram_word_u wr_word,     // Expected value of every word.
    output logic        mem_wr_req,  // Level, held until mem_wr_done.
    input  logic        mem_wr_done,
    output logic        mem_rd_req,  // Level, held until mem_rd_done.
    input  logic        mem_rd_done,
    input  sdram_word_u mem_rd_data0,
    input  sdram_word_u mem_rd_data1,
    input  sdram_word_u mem_rd_data2,
    input  sdram_word_u mem_rd_data3,
    output logic        burst_ok,
    output logic        error_led,
    output logic        uart_txd
);

    localparam int WIDX_W = $clog2(`BURST_WORDS);

    // FSM encoding.
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_WRITE = 3'd1;
    localparam logic [2:0] ST_READ  = 3'd2;
    localparam logic [2:0] ST_SEND  = 3'd3;
    localparam logic [2:0] ST_WAIT  = 3'd4;
    localparam logic [2:0] ST_HALT  = 3'd5;

    logic [2:0]        state;
    logic [WIDX_W-1:0] w_idx;  // Word under test.
    logic              lo_sel; // Low byte of the word is next.

    sdram_word_u rd_words [`BURST_WORDS]; // Read-back copy of the burst.
    sdram_word_u cur_word;
    logic        word_match;

    logic        tx_start;
    sdram_byte_t tx_byte;
    logic        tx_busy;

    assign cur_word   = rd_words[w_idx];
    assign word_match = (cur_word.word == wr_word.word);

    // High byte first, then low.
    assign tx_byte  = lo_sel ? cur_word.bytes.lo : cur_word.bytes.hi;
    // A bad word never reaches the line.
    assign tx_start = (state == ST_SEND) && (lo_sel || word_match);

    //////////////////////////////////////////////////
    // Read-back capture.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210) begin
        if (state == ST_READ && mem_rd_done) begin // Data valid with the done pulse.
            rd_words[0] <= mem_rd_data0;
            rd_words[1] <= mem_rd_data1;
            rd_words[2] <= mem_rd_data2;
            rd_words[3] <= mem_rd_data3;
        end
    end

    //////////////////////////////////////////////////
    // Write, read back, compare and report.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            w_idx      <= '0;
            lo_sel     <= 1'b0;
            mem_wr_req <= 1'b0;
            mem_rd_req <= 1'b0;
            burst_ok   <= 1'b0;
            error_led  <= 1'b0;
        end else begin
            burst_ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (burst_start) begin
                        mem_wr_req <= 1'b1;
                        state      <= ST_WRITE;
                    end
                end

                ST_WRITE: begin
                    if (mem_wr_done) begin
                        mem_wr_req <= 1'b0;
                        mem_rd_req <= 1'b1; // Same address, straight into the read.
                        state      <= ST_READ;
                    end
                end

                ST_READ: begin
                    if (mem_rd_done) begin
                        mem_rd_req <= 1'b0;
                        w_idx      <= '0;
                        lo_sel     <= 1'b0;
                        state      <= ST_SEND;
                    end
                end

                ST_SEND: begin
                    if (lo_sel || word_match) begin
                        state <= ST_WAIT; // UART took the byte this cycle.
                    end else begin
                        error_led <= 1'b1; // First mismatch stops the run.
                        state     <= ST_HALT;
                    end
                end

                ST_WAIT: begin
                    if (!tx_busy) begin
                        if (!lo_sel) begin
                            lo_sel <= 1'b1;
                            state  <= ST_SEND;
                        end else if (w_idx == WIDX_W'(`BURST_WORDS - 1)) begin
                            burst_ok <= 1'b1; // All eight bytes out.
                            state    <= ST_IDLE;
                        end else begin
                            w_idx  <= w_idx + 1'b1;
                            lo_sel <= 1'b0;
                            state  <= ST_SEND;
                        end
                    end
                end

                ST_HALT: begin
                    state <= ST_HALT; // Error halt, reset only.
                end

                default: begin
                    state <= ST_HALT;
                end
            endcase
        end
    end

    uart_byte_tx #(
        .baud_div (baud_div)
    ) uart_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_byte        (tx_byte),
        .tx_busy        (tx_busy),
        .uart_txd       (uart_txd)
    );

endmodule

// File: rtl/sdram_self_test.sv
`timescale 1ns/1ns

`include "sdram_test_settings.svh"

module sdram_self_test
    import sdram_test_pkg::*;
#(
    parameter int baud_div    = `UART_BAUD_DIV_DEFAULT,
    parameter int pace_cycles = `PACE_CYCLES_DEFAULT,
    parameter int frame_words = `FRAME_WORDS_DEFAULT
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,
    // Memory controller side.
    output logic        mem_wr_req,
    output logic        mem_rd_req,
    output sdram_addr_t mem_addr,
    output sdram_word_u mem_wr_data0,
    output sdram_word_u mem_wr_data1,
    output sdram_word_u mem_wr_data2,
    output sdram_word_u mem_wr_data3,
    input  logic        mem_wr_done,
    input  logic        mem_rd_done,
    input  sdram_word_u mem_rd_data0,
    input  sdram_word_u mem_rd_data1,
    input  sdram_word_u mem_rd_data2,
    input  sdram_word_u mem_rd_data3,
    // Status.
    output logic        uart_txd,
    output logic        error_led
);

    logic        burst_start;
    logic        burst_ok;
    sdram_word_u wr_word;

    // One pattern word fills the whole burst.
    assign mem_wr_data0 = wr_word;
    assign mem_wr_data1 = wr_word;
    assign mem_wr_data2 = wr_word;
    assign mem_wr_data3 = wr_word;

    burst_pattern_gen #(
        .pace_cycles (pace_cycles),
        .frame_words (frame_words)
    ) pattern_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .burst_ok       (burst_ok),
        .burst_start    (burst_start),
        .mem_addr       (mem_addr),
        .wr_word        (wr_word)
    );

    burst_verifier #(
        .baud_div (baud_div)
    ) verifier_i (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .burst_start    (burst_start),
        .wr_word        (wr_word),
        .mem_wr_req     (mem_wr_req),
        .mem_wr_done    (mem_wr_done),
        .mem_rd_req     (mem_rd_req),
        .mem_rd_done    (mem_rd_done),
        .mem_rd_data0   (mem_rd_data0),
        .mem_rd_data1   (mem_rd_data1),
        .mem_rd_data2   (mem_rd_data2),
        .mem_rd_data3   (mem_rd_data3),
        .burst_ok       (burst_ok),
        .error_led      (error_led),
        .uart_txd       (uart_txd)
    );

endmodule

// File: rtl/sdram_test_pkg.sv
`include "sdram_test_settings.svh"

package sdram_test_pkg;

    //////////////////////////////////////////////////
    // Shared types for the self-test.
    //////////////////////////////////////////////////

    // One SDRAM word address.
    typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;

    // One UART payload byte, half a word.
    typedef logic [`SDRAM_WORD_W/2-1:0] sdram_byte_t;

    // High byte goes out first on the UART.
    typedef struct packed {
        sdram_byte_t hi; // Bits 15:8.
        sdram_byte_t lo; // Bits 7:0.
    } sdram_byte_pair_t;

    // Same 16 bits seen two ways.
    // Whole word for the compare, byte pair for the UART.
    typedef union packed {
        logic [`SDRAM_WORD_W-1:0] word;
        sdram_byte_pair_t bytes;
    } sdram_word_u;

endpackage

// File: rtl/sdram_test_settings.svh
`ifndef SDRAM_TEST_SETTINGS_SVH
`define SDRAM_TEST_SETTINGS_SVH

//////////////////////////////////////////////////
// SDRAM geometry.
//////////////////////////////////////////////////

// Bank(2) + row(13) + column(9).
`define SDRAM_ADDR_W 24
`define SDRAM_WORD_W 16 // One x16 SDRAM word.
`define BURST_WORDS 4 // Words per burst, also the address step.

//////////////////////////////////////////////////
// UART framing and default timing.
//////////////////////////////////////////////////

// Start bit, eight data bits LSB first, two stop bits.
`define UART_FRAME_BITS 11

// 133.33 MHz / 115200 baud.
`define UART_BAUD_DIV_DEFAULT 1157

// Pause after each good burst.
`define PACE_CYCLES_DEFAULT 2222222

// 480 x 800 panel, one word per pixel.
`define FRAME_WORDS_DEFAULT 384000

`endif

// File: rtl/uart_byte_tx.sv
`timescale 1ns/1ns

`include "sdram_test_settings.svh"

module uart_byte_tx
    import sdram_test_pkg::*;
#(
    parameter int baud_div = `UART_BAUD_DIV_DEFAULT // Clocks per bit.
) (
    input  logic        clk_133MHz_210,
    input  logic        rst_n,
    input  logic        tx_start, // One-cycle launch pulse.
    input  sdram_byte_t tx_byte,
    output logic        tx_busy,
    output logic        uart_txd
);

    localparam int FRAME_W = `UART_FRAME_BITS;
    localparam int BIT_W   = $clog2(FRAME_W);
    localparam int CYC_W   = $clog2(baud_div + 1);

    logic [FRAME_W-1:0] frame_sr; // LSB is on the line.
    logic [BIT_W-1:0]   bit_cnt;
    logic [CYC_W-1:0]   cyc_cnt;

    // Line follows the shifter; all ones when idle.
    assign uart_txd = frame_sr[0];

    //////////////////////////////////////////////////
    // Frame shifter.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame_sr <= '1; // Idle high.
            bit_cnt  <= '0;
            cyc_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Stop bits high, then data, start bit low.
                frame_sr <= {{(FRAME_W - 9){1'b1}}, tx_byte, 1'b0};
                bit_cnt  <= '0;
                cyc_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else begin
            if (cyc_cnt == CYC_W'(baud_div - 1)) begin // End of one bit.
                cyc_cnt  <= '0;
                frame_sr <= {1'b1, frame_sr[FRAME_W-1:1]}; // Refill with idle.
                if (bit_cnt == BIT_W'(FRAME_W - 1)) begin
                    tx_busy <= 1'b0; // Last stop bit done.
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

// File: sdram_self_test.f
+incdir+rtl
+incdir+testbench
rtl/sdram_test_pkg.sv
rtl/uart_byte_tx.sv
rtl/burst_pattern_gen.sv
rtl/burst_verifier.sv
rtl/sdram_self_test.sv
testbench/tb_sdram_self_test.sv

// File: testbench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////////////////////////
// Run-wide error and test counters.
//////////////////////////////////////////////////

int err_count  = 0;
int test_count = 0;
int fail_count = 0; // Tests with at least one error.

// Plain-word failure.
task automatic report_error(string what);
    err_count++;
    $display("error at %0t ns: %s", $time, what);
endtask

// Wrong value, shown in hex.
task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    err_count++;
    $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
endtask

//////////////////////////////////////////////////
// Compares, one per kind of result.
//////////////////////////////////////////////////

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_mismatch(name, got, exp);
endtask

task automatic check_addr(string name, sdram_addr_t got, sdram_addr_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
endtask

task automatic check_word(string name, sdram_word_u got, sdram_word_u exp);
    if (got.word !== exp.word) report_mismatch(name, got.word, exp.word); // Whole-word view.
endtask

task automatic check_byte(string name, sdram_byte_t got, sdram_byte_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
endtask

// Exact count, or a lower bound while the DUT still runs.
task automatic check_count(string name, int got, int exp, logic exact);
    if (exact ? (got != exp) : (got < exp)) begin
        report_error($sformatf("%s count is %0d, expected %0d", name, got, exp));
    end
endtask

task automatic finish_test(string name, int errs_before);
    test_count++;
    if (err_count != errs_before) fail_count++;
    $display("%s finished, %0d errors", name, err_count - errs_before);
endtask

`endif

// File: testbench/tb_sdram_self_test.sv
`timescale 1ns/1ns

`include "sdram_test_settings.svh"

module tb_sdram_self_test
    import sdram_test_pkg::*;
();

    localparam int BAUD_DIV   = 8;     // Clocks per UART bit.
    localparam int WAIT_LIMIT = 20000; // Cycles before a wait gives up.

    logic        clk_133MHz_210;
    logic        rst_n;
    logic        mem_wr_req;
    logic        mem_rd_req;
    sdram_addr_t mem_addr;
    sdram_word_u mem_wr_data0, mem_wr_data1, mem_wr_data2, mem_wr_data3;
    logic        mem_wr_done;
    logic        mem_rd_done;
    sdram_word_u mem_rd_data0, mem_rd_data1, mem_rd_data2, mem_rd_data3;
    logic        uart_txd;
    logic        error_led;

    logic        model_en   = 1'b0; // Memory model answers requests.
    logic        model_busy = 1'b0;
    logic        rand_delay = 1'b0; // Done after 1 to 20 cycles.
    int          bad_burst  = -1;   // Read-back to corrupt.
    int          bad_word   = 2;
    int          rd_count   = 0;
    int          reset_gen  = 0;    // Frames cut by reset are dropped.
    sdram_word_u mem_model [sdram_addr_t];
    sdram_addr_t wr_addr_q [$];
    sdram_addr_t rd_addr_q [$];
    sdram_word_u wr_data_q [$];
    sdram_byte_t rx_q [$]; // Bytes seen on uart_txd.

    `include "tb_checks.svh"

    sdram_self_test #(
        .baud_div    (BAUD_DIV),
        .pace_cycles (16),
        .frame_words (16) // Four bursts.
    ) dut_i (.*);

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #20 clk_133MHz_210 = ~clk_133MHz_210;
    end

    //////////////////////////////////////////////////
    // Memory controller model.
    //////////////////////////////////////////////////
    initial begin : mem_ctrl
        logic        is_wr;
        int          delay;
        sdram_addr_t addr;
        sdram_word_u wdata [`BURST_WORDS];
        sdram_word_u rdata [`BURST_WORDS];
        void'($urandom(2)); // Fixed seed.
        forever begin
            @(negedge clk_133MHz_210);
            if (model_en && (mem_wr_req || mem_rd_req)) begin
                model_busy = 1'b1;
                is_wr      = mem_wr_req;
                addr       = mem_addr;
                if (mem_wr_req && mem_rd_req) begin
                    report_error("write and read requests are high together");
                end
                delay = rand_delay ? $urandom_range(20, 1) : 2;
                for (int i = 1; i < delay; i++) begin // Request must hold.
                    @(negedge clk_133MHz_210);
                    if ((is_wr ? mem_wr_req : mem_rd_req) !== 1'b1) begin
                        report_error("request dropped before its done pulse");
                    end
                end
                if (is_wr) begin
                    wdata = '{mem_wr_data0, mem_wr_data1, mem_wr_data2, mem_wr_data3};
                    wr_addr_q.push_back(addr);
                    for (int i = 0; i < `BURST_WORDS; i++) begin
                        wr_data_q.push_back(wdata[i]);
                        mem_model[sdram_addr_t'(addr + i)] = wdata[i];
                    end
                    mem_wr_done = 1'b1;
                end else begin
                    rd_addr_q.push_back(addr);
                    for (int i = 0; i < `BURST_WORDS; i++) begin
                        rdata[i] = mem_model[sdram_addr_t'(addr + i)];
                    end
                    if (rd_count == bad_burst) rdata[bad_word].word = ~rdata[bad_word].word;
                    mem_rd_data0 = rdata[0]; // Valid with the done pulse.
                    mem_rd_data1 = rdata[1];
                    mem_rd_data2 = rdata[2];
                    mem_rd_data3 = rdata[3];
                    mem_rd_done  = 1'b1;
                    rd_count++;
                end
                @(negedge clk_133MHz_210);
                mem_wr_done = 1'b0;
                mem_rd_done = 1'b0;
                if ((is_wr ? mem_wr_req : mem_rd_req) !== 1'b0) begin
                    report_error("request still high after its done pulse");
                end
                model_busy = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // UART receiver, mid-bit sampling.
    //////////////////////////////////////////////////
    always begin : uart_rx
        sdram_byte_t rx_byte;
        int          gen;
        @(negedge clk_133MHz_210);
        if (rst_n === 1'b1 && uart_txd === 1'b0) begin // Start bit.
            gen = reset_gen;
            repeat (BAUD_DIV / 2) @(negedge clk_133MHz_210);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                rx_byte[i] = uart_txd; // LSB first.
            end
            for (int i = 0; i < 2; i++) begin // Two stop bits.
                repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                if (uart_txd !== 1'b1 && gen == reset_gen) begin
                    report_error("UART frame error, stop bit low");
                end
            end
            if (gen == reset_gen) rx_q.push_back(rx_byte);
        end
    end

    task automatic abort_run(string what);
        $display("timeout waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic check_idle_outputs();
        check_bit("uart_txd", uart_txd, 1'b1);
        check_bit("error_led", error_led, 1'b0);
        check_bit("mem_wr_req", mem_wr_req, 1'b0);
        check_bit("mem_rd_req", mem_rd_req, 1'b0);
    endtask

    // Quiet the model, then hold reset 4 cycles.
    task automatic apply_reset();
        int waited;
        waited   = 0;
        model_en = 1'b0;
        @(negedge clk_133MHz_210);
        while (model_busy) begin
            @(negedge clk_133MHz_210);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("the memory model to go idle");
        end
        rst_n = 1'b0;
        reset_gen++;
        repeat (4) begin
            @(negedge clk_133MHz_210);
            check_idle_outputs();
        end
        mem_model.delete();
        wr_addr_q.delete();
        rd_addr_q.delete();
        wr_data_q.delete();
        rx_q.delete();
        rd_count = 0;
        model_en = 1'b1;
        rst_n    = 1'b1;
    endtask

    task automatic test_reset_state();
        int errs;
        errs = err_count;
        apply_reset();
        @(negedge clk_133MHz_210); // First cycle out of reset.
        check_idle_outputs();
        finish_test("reset_state", errs);
    endtask

    // Bursts b = 0.. at address 4b with data b; halts after the last one or a bad word.
    task automatic run_bursts(string name, int n_bursts, int bad, logic rnd, logic halts);
        sdram_byte_t exp_q [$];
        sdram_word_u pattern;
        int          errs;
        int          n_run;
        int          waited;
        errs       = err_count;
        bad_burst  = bad;
        rand_delay = rnd;
        n_run      = (bad >= 0) ? bad + 1 : n_bursts;
        apply_reset();
        for (int b = 0; b < n_run; b++) begin
            pattern.word = b;
            for (int w = 0; w < `BURST_WORDS && !(b == bad && w >= bad_word); w++) begin
                exp_q.push_back(pattern.bytes.hi); // High byte first.
                exp_q.push_back(pattern.bytes.lo);
            end
        end
        waited = 0;
        while (rx_q.size() < exp_q.size() || (bad >= 0 && error_led !== 1'b1)) begin
            @(negedge clk_133MHz_210);
            waited++;
            if (waited > WAIT_LIMIT) abort_run({name, " bytes and status"});
        end
        waited = 0;
        while (halts && waited < 600) begin // Halted run stays silent.
            @(negedge clk_133MHz_210);
            waited++;
            if (mem_wr_req || mem_rd_req || !uart_txd) begin
                report_error("request or UART frame after the run halted");
                waited = 600;
            end
        end
        check_bit("error_led", error_led, bad >= 0);
        if (halts) begin // Extra frames show only after the silent window.
            check_count("UART byte", rx_q.size(), exp_q.size(), 1'b1);
        end
        check_count("write burst", wr_addr_q.size(), n_run, halts);
        check_count("read burst", rd_addr_q.size(), n_run, halts);
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_byte($sformatf("uart byte %0d", i), rx_q[i], exp_q[i]);
        end
        for (int b = 0; b < n_run && b < rd_addr_q.size(); b++) begin
            pattern.word = b;
            check_addr("write mem_addr", wr_addr_q[b], sdram_addr_t'(b * `BURST_WORDS));
            check_addr("read mem_addr", rd_addr_q[b], sdram_addr_t'(b * `BURST_WORDS));
            for (int w = 0; w < `BURST_WORDS; w++) begin
                check_word($sformatf("mem_wr_data%0d", w),
                           wr_data_q[b * `BURST_WORDS + w], pattern);
            end
        end
        finish_test(name, errs);
    endtask

    initial begin
        rst_n        = 1'b0;
        mem_wr_done  = 1'b0;
        mem_rd_done  = 1'b0;
        mem_rd_data0 = '0;
        mem_rd_data1 = '0;
        mem_rd_data2 = '0;
        mem_rd_data3 = '0;
        test_reset_state();
        run_bursts("one_burst", 1, -1, 1'b0, 1'b0);
        run_bursts("full_frame", 4, -1, 1'b0, 1'b1);
        run_bursts("corrupt_read", 4, 1, 1'b0, 1'b1); // Word 2 of burst 1.
        run_bursts("back_pressure", 4, -1, 1'b1, 1'b1);
        $display("%0d tests run, %0d failing, %0d errors", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
